// File: Makefile
SRCS := $(wildcard src/*.sv dv/*.sv)

.PHONY: run clean

run: obj_dir/Vtb_arcade_glue
	./obj_dir/Vtb_arcade_glue

obj_dir/Vtb_arcade_glue: list.f $(SRCS)
	verilator --binary --timing --top-module tb_arcade_glue -f list.f

clean:
	rm -rf obj_dir

// File: dv/tb_arcade_glue.sv
`timescale 1ns/1ps
`default_nettype none

module tb_arcade_glue;
	import arcade_pkg::*;

	logic        clock_48;
	logic        arst_n;
	logic        ioctl_download;
	logic [7:0]  ioctl_index;
	logic        ioctl_wr;
	logic [24:0] ioctl_addr;
	logic [7:0]  ioctl_dout;
	logic [14:0] cpu_addr;
	logic [12:0] snd_addr;
	logic [7:0]  cpu_data;
	logic [7:0]  snd_data;
	logic        cfg_wr;
	logic [1:0]  cfg_addr;
	logic [7:0]  cfg_wdata;
	logic [7:0]  cfg_rdata;
	logic        button_reset;
	logic        core_reset;
	logic        key_strobe;
	logic        key_pressed;
	logic [7:0]  key_code;
	logic [5:0]  joystick_0;
	logic [5:0]  joystick_1;
	logic [5:0]  inp0;
	logic [5:0]  inp1;
	logic [2:0]  inp2;
	logic [2:0]  r;
	logic [2:0]  g;
	logic [1:0]  b;
	logic        hblank;
	logic        vblank;
	logic        hsync;
	logic        vsync;
	logic        vpos_odd;
	logic [5:0]  vga_r;
	logic [5:0]  vga_g;
	logic [5:0]  vga_b;
	logic        vga_hs;
	logic        vga_vs;

	logic [31:0] lcg_state;
	logic [7:0]  rom_model [int unsigned]; // expected rom bytes by download address
	logic [7:0]  key_list [9];
	logic [8:0]  held;    // up down left right fire1 fire2 coin start1 start2
	logic        rot_cfg; // rotate as last written

	arcade_glue_top u_arcade_glue_top (.*);

	initial begin
		clock_48 = 1'b0;
		forever #4 clock_48 = ~clock_48;
	end

	function automatic logic [7:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	task automatic wait_core_reset(input logic level);
		int cycles;
		cycles = 0;
		while (core_reset !== level && cycles < 32) begin
			@(negedge clock_48);
			cycles++;
		end
		if (core_reset !== level) begin
			$display("RESULT: FAIL");
			$fatal(1, "core_reset did not go to %0b within 32 cycles", level);
		end
	endtask

	task automatic cfg_write(input logic [1:0] addr, input logic [7:0] data);
		cfg_addr  = addr;
		cfg_wdata = data;
		cfg_wr    = 1'b1;
		@(negedge clock_48);
		cfg_wr = 1'b0;
	endtask

	task automatic cfg_expect(input logic [1:0] addr, input logic [7:0] exp);
		cfg_addr = addr;
		@(negedge clock_48);
		check("cfg_rdata", 32'(cfg_rdata), 32'(exp));
	endtask

	task automatic send_byte(input logic [24:0] addr, input logic [7:0] data);
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr   = 1'b1;
		@(negedge clock_48);
		ioctl_wr = 1'b0;
		repeat (3) @(negedge clock_48); // 4 cycles per byte
	endtask

	task automatic read_expect(input int unsigned a, input logic [7:0] exp);
		if (a < 32'h8000) begin
			cpu_addr = 15'(a);
			@(negedge clock_48);
			check("cpu_data", 32'(cpu_data), 32'(exp));
		end else begin
			snd_addr = 13'(a - 32'(snd_base));
			@(negedge clock_48);
			check("snd_data", 32'(snd_data), 32'(exp));
		end
	endtask

	task automatic strobe_key(input logic [7:0] code, input logic pressed);
		key_code    = code;
		key_pressed = pressed;
		key_strobe  = 1'b1;
		for (int i = 0; i < 9; i++)
			if (key_list[i] == code)
				held[i] = pressed; // unknown codes leave the model alone
		@(negedge clock_48);
		key_strobe = 1'b0;
	endtask

	// game view: {fire2, fire1, left, down, right, up}
	function automatic logic [5:0] expect_inp0(input logic [8:0] k, input logic [5:0] j,
			input logic rot);
		logic up;
		logic down;
		logic left;
		logic right;
		up    = k[0] | j[3];
		down  = k[1] | j[2];
		left  = k[2] | j[1];
		right = k[3] | j[0];
		if (rot)
			return {k[5] | j[5], k[4] | j[4], down, right, up, left};
		return {k[5] | j[5], k[4] | j[4], left, down, right, up};
	endfunction

	function automatic logic [5:0] expect_colour(input logic [5:0] v, input logic blank,
			input logic odd, input logic [1:0] s);
		int x;
		if (blank)
			return 6'd0;
		x = int'(v);
		if (odd)
			x = x - (x * int'(s)) / 4;
		return 6'(x);
	endfunction

	task automatic check_controls();
		check("inp0", 32'(inp0), 32'(expect_inp0(held, joystick_0 | joystick_1, rot_cfg)));
		check("inp1", 32'(inp1), 32'(expect_inp0(held, joystick_0 | joystick_1, rot_cfg)));
		check("inp2", 32'(inp2), 32'({held[6], held[8], held[7]}));
	endtask

	task automatic test_reset_state();
		// no clock edge yet since release, outputs still hold their reset values
		check("vga_r", 32'(vga_r), 32'd0);
		check("vga_g", 32'(vga_g), 32'd0);
		check("vga_b", 32'(vga_b), 32'd0);
		check("vga_hs", 32'(vga_hs), 32'd0);
		check("vga_vs", 32'(vga_vs), 32'd0);
		r     = 3'd0;
		g     = 3'd0;
		b     = 2'd0;
		hsync = 1'b0;
		vsync = 1'b0;
		check("core_reset", 32'(core_reset), 32'd1);
		check_controls();
		cfg_expect(reg_status, 8'h02); // core_reset bit only
	endtask

	task automatic test_download();
		logic [7:0]  stray;
		int unsigned a;
		ioctl_download = 1'b1;
		@(negedge clock_48);
		for (int unsigned i = 0; i < 64; i++) begin
			rom_model[i] = next_random();
			send_byte(25'(i), rom_model[i]);
			a = 32'(snd_base) + i;
			rom_model[a] = next_random();
			send_byte(25'(a), rom_model[a]);
		end
		rom_model[32'h1000] = next_random();
		send_byte(25'h1000, rom_model[32'h1000]);
		// byte in the gap must differ from what sits at its aliases
		stray = next_random();
		while (stray == rom_model[32'h1000] || stray == rom_model[32'(snd_base)])
			stray = stray + 8'd1;
		send_byte(25'h9000, stray);
		cpu_addr = 15'd0;
		@(negedge clock_48);
		check("cpu_data", 32'(cpu_data), 32'd0); // blocked during download
		ioctl_download = 1'b0;
		wait_core_reset(1'b0);
		foreach (rom_model[k])
			read_expect(k, rom_model[k]);
	endtask

	task automatic test_soft_reset();
		cfg_write(reg_ctrl, 8'h01);
		wait_core_reset(1'b1);
		cfg_expect(reg_ctrl, 8'h01);
		cfg_expect(reg_status, 8'h03);
		cfg_write(reg_ctrl, 8'h00);
		wait_core_reset(1'b0);
		cfg_expect(reg_status, 8'h01);
		button_reset = 1'b1;
		wait_core_reset(1'b1);
		button_reset = 1'b0;
		wait_core_reset(1'b0);
	endtask

	task automatic test_keys();
		for (int rot = 0; rot < 2; rot++) begin
			rot_cfg = rot[0];
			cfg_write(reg_ctrl, {6'd0, rot[0], 1'b0});
			for (int i = 0; i < 9; i++) begin
				strobe_key(key_list[i], 1'b1);
				check_controls();
			end
			strobe_key(8'h1C, 1'b0); // not mapped
			check_controls();
			for (int i = 0; i < 9; i++) begin
				strobe_key(key_list[i], 1'b0);
				check_controls();
			end
		end
	endtask

	task automatic test_joysticks();
		for (int rot = 0; rot < 2; rot++) begin
			rot_cfg = rot[0];
			cfg_write(reg_ctrl, {6'd0, rot[0], 1'b0});
			strobe_key(key_up, 1'b1);
			strobe_key(key_fire1, 1'b1);
			for (int n = 0; n < 8; n++) begin
				joystick_0 = 6'(next_random());
				joystick_1 = 6'(next_random());
				@(negedge clock_48);
				check_controls();
			end
			strobe_key(key_up, 1'b0);
			strobe_key(key_fire1, 1'b0);
			check_controls(); // joysticks only
		end
		joystick_0 = 6'd0;
		joystick_1 = 6'd0;
		rot_cfg    = 1'b0;
		cfg_write(reg_ctrl, 8'h00);
	endtask

	task automatic test_video();
		logic [7:0] px;
		for (int s = 0; s < 4; s++) begin
			cfg_write(reg_video, 8'(s));
			for (int n = 0; n < 12; n++) begin
				px       = next_random();
				r        = px[7:5];
				g        = px[4:2];
				b        = px[1:0];
				vpos_odd = n[0];
				hblank   = (n % 4 == 1);
				vblank   = (n % 4 == 2);
				hsync    = n[1];
				vsync    = n[2];
				@(negedge clock_48);
				check("vga_r", 32'(vga_r), 32'(expect_colour({r, r}, hblank | vblank,
					vpos_odd, 2'(s))));
				check("vga_g", 32'(vga_g), 32'(expect_colour({g, g}, hblank | vblank,
					vpos_odd, 2'(s))));
				check("vga_b", 32'(vga_b), 32'(expect_colour({b, b, b}, hblank | vblank,
					vpos_odd, 2'(s))));
				check("vga_hs", 32'(vga_hs), 32'(hsync));
				check("vga_vs", 32'(vga_vs), 32'(vsync));
			end
		end
	endtask

	initial begin
		lcg_state = 32'd82;
		key_list  = '{key_up, key_down, key_left, key_right, key_fire1, key_fire2,
			key_coin, key_start1, key_start2};
		held           = 9'd0;
		rot_cfg        = 1'b0;
		arst_n         = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index    = 8'd0; // game rom
		ioctl_wr       = 1'b0;
		ioctl_addr     = 25'd0;
		ioctl_dout     = 8'd0;
		cpu_addr       = 15'd0;
		snd_addr       = 13'd0;
		cfg_wr         = 1'b0;
		cfg_addr       = 2'd0;
		cfg_wdata      = 8'd0;
		button_reset   = 1'b0;
		key_strobe     = 1'b0;
		key_pressed    = 1'b0;
		key_code       = 8'd0;
		joystick_0     = 6'd0;
		joystick_1     = 6'd0;
		r              = 3'd5; // live pixel while in reset
		g              = 3'd3;
		b              = 2'd2;
		hblank         = 1'b0;
		vblank         = 1'b0;
		hsync          = 1'b1;
		vsync          = 1'b1;
		vpos_odd       = 1'b0;
		repeat (8) @(posedge clock_48);
		@(negedge clock_48);
		arst_n = 1'b1;
		test_reset_state();
		test_download();
		test_soft_reset();
		test_keys();
		test_joysticks();
		test_video();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
src/arcade_pkg.sv
src/ioctl_if.sv
src/rom_wr_if.sv
src/rom_loader.sv
src/rom_banks.sv
src/option_regs.sv
src/control_mapper.sv
src/video_out.sv
src/arcade_glue_top.sv
dv/tb_arcade_glue.sv

// File: src/arcade_glue_top.sv
`timescale 1ns/1ps
`default_nettype none

module arcade_glue_top #(
	parameter int CPU_AW = arcade_pkg::cpu_rom_aw,
	parameter int SND_AW = arcade_pkg::snd_rom_aw
) (
	input  wire              clock_48,
	input  wire              arst_n,
	// rom download from the data-io receiver
	input  wire              ioctl_download,
	input  wire [7:0]        ioctl_index,
	input  wire              ioctl_wr,
	input  wire [24:0]       ioctl_addr,
	input  wire [7:0]        ioctl_dout,
	// core rom reads
	input  wire [CPU_AW-1:0] cpu_addr,
	input  wire [SND_AW-1:0] snd_addr,
	output logic [7:0]       cpu_data,
	output logic [7:0]       snd_data,
	// configuration
	input  wire              cfg_wr,
	input  wire [1:0]        cfg_addr,
	input  wire [7:0]        cfg_wdata,
	output logic [7:0]       cfg_rdata,
	input  wire              button_reset,
	output logic             core_reset,
	// keyboard and joysticks
	input  wire              key_strobe,
	input  wire              key_pressed,
	input  wire [7:0]        key_code,
	input  wire [5:0]        joystick_0,
	input  wire [5:0]        joystick_1,
	output logic [5:0]       inp0,
	output logic [5:0]       inp1,
	output logic [2:0]       inp2,
	// core pixel in, vga out
	input  wire [2:0]        r,
	input  wire [2:0]        g,
	input  wire [1:0]        b,
	input  wire              hblank,
	input  wire              vblank,
	input  wire              hsync,
	input  wire              vsync,
	input  wire              vpos_odd,
	output logic [5:0]       vga_r,
	output logic [5:0]       vga_g,
	output logic [5:0]       vga_b,
	output logic             vga_hs,
	output logic             vga_vs
);

	logic       rom_loaded;
	logic       rotate;
	logic [1:0] scanlines;

	ioctl_if  u_ioctl ();
	rom_wr_if u_rom_wr ();

	assign u_ioctl.download = ioctl_download;
	assign u_ioctl.index    = ioctl_index;
	assign u_ioctl.wr       = ioctl_wr;
	assign u_ioctl.addr     = ioctl_addr;
	assign u_ioctl.dout     = ioctl_dout;

	rom_loader u_rom_loader (
		.clock_48   (clock_48),
		.arst_n     (arst_n),
		.ioctl      (u_ioctl.sink),
		.wr_port    (u_rom_wr.loader),
		.rom_loaded (rom_loaded)
	);

	rom_banks #(
		.CPU_AW (CPU_AW),
		.SND_AW (SND_AW)
	) u_rom_banks (
		.clock_48 (clock_48),
		.wr_port  (u_rom_wr.banks),
		.download (ioctl_download),
		.cpu_addr (cpu_addr),
		.snd_addr (snd_addr),
		.cpu_data (cpu_data),
		.snd_data (snd_data)
	);

	option_regs u_option_regs (
		.clock_48     (clock_48),
		.arst_n       (arst_n),
		.cfg_wr       (cfg_wr),
		.cfg_addr     (cfg_addr),
		.cfg_wdata    (cfg_wdata),
		.cfg_rdata    (cfg_rdata),
		.download     (ioctl_download),
		.rom_loaded   (rom_loaded),
		.button_reset (button_reset),
		.rotate       (rotate),
		.scanlines    (scanlines),
		.core_reset   (core_reset)
	);

	control_mapper u_control_mapper (
		.clock_48    (clock_48),
		.arst_n      (arst_n),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.joystick_0  (joystick_0),
		.joystick_1  (joystick_1),
		.rotate      (rotate),
		.inp0        (inp0),
		.inp1        (inp1),
		.inp2        (inp2)
	);

	video_out u_video_out (
		.clock_48  (clock_48),
		.arst_n    (arst_n),
		.r         (r),
		.g         (g),
		.b         (b),
		.hblank    (hblank),
		.vblank    (vblank),
		.hsync     (hsync),
		.vsync     (vsync),
		.vpos_odd  (vpos_odd),
		.scanlines (scanlines),
		.vga_r     (vga_r),
		.vga_g     (vga_g),
		.vga_b     (vga_b),
		.vga_hs    (vga_hs),
		.vga_vs    (vga_vs)
	);

endmodule

`default_nettype wire

// File: src/arcade_pkg.sv
`default_nettype none

package arcade_pkg;

	// rom byte-address widths
	localparam int cpu_rom_aw = 15; // 32k main program
	localparam int snd_rom_aw = 13; // 8k sound program

	localparam logic [24:0] snd_base = 25'h10000; // sound region in the download map

	// download regions, region_none bytes are dropped
	typedef enum logic [1:0] {
		region_cpu,
		region_snd,
		region_none
	} rom_region_t;

	// ps/2 set 2 scan codes
	localparam logic [7:0] key_up     = 8'h75;
	localparam logic [7:0] key_down   = 8'h72;
	localparam logic [7:0] key_left   = 8'h6B;
	localparam logic [7:0] key_right  = 8'h74;
	localparam logic [7:0] key_coin   = 8'h76; // esc
	localparam logic [7:0] key_start1 = 8'h05; // f1
	localparam logic [7:0] key_start2 = 8'h06; // f2
	localparam logic [7:0] key_fire2  = 8'h11; // alt
	localparam logic [7:0] key_fire1  = 8'h29; // space

	// configuration register map
	localparam logic [1:0] reg_ctrl   = 2'd0;
	localparam logic [1:0] reg_video  = 2'd1;
	localparam logic [1:0] reg_status = 2'd2; // read only

endpackage

`default_nettype wire

// File: src/control_mapper.sv
`timescale 1ns/1ps
`default_nettype none

module control_mapper (
	input  wire        clock_48,
	input  wire        arst_n,
	input  wire        key_strobe,
	input  wire        key_pressed,
	input  wire [7:0]  key_code,
	input  wire [5:0]  joystick_0, // {fire2, fire1, up, down, left, right}
	input  wire [5:0]  joystick_1,
	input  wire        rotate,
	output logic [5:0] inp0,
	output logic [5:0] inp1,
	output logic [2:0] inp2
);
	import arcade_pkg::*;

	// keyboard button state
	logic btn_up;
	logic btn_down;
	logic btn_left;
	logic btn_right;
	logic btn_fire1;
	logic btn_fire2;
	logic btn_coin;
	logic btn_start1;
	logic btn_start2;

	// merged directions before rotation
	logic d_up;
	logic d_down;
	logic d_left;
	logic d_right;

	// game view
	logic m_up;
	logic m_down;
	logic m_left;
	logic m_right;
	logic m_fire1;
	logic m_fire2;

	always_ff @(posedge clock_48 or negedge arst_n) begin
		if (!arst_n) begin
			btn_up     <= 1'b0;
			btn_down   <= 1'b0;
			btn_left   <= 1'b0;
			btn_right  <= 1'b0;
			btn_fire1  <= 1'b0;
			btn_fire2  <= 1'b0;
			btn_coin   <= 1'b0;
			btn_start1 <= 1'b0;
			btn_start2 <= 1'b0;
		end else if (key_strobe) begin
			case (key_code)
				key_up:     btn_up     <= key_pressed;
				key_down:   btn_down   <= key_pressed;
				key_left:   btn_left   <= key_pressed;
				key_right:  btn_right  <= key_pressed;
				key_fire1:  btn_fire1  <= key_pressed;
				key_fire2:  btn_fire2  <= key_pressed;
				key_coin:   btn_coin   <= key_pressed;
				key_start1: btn_start1 <= key_pressed;
				key_start2: btn_start2 <= key_pressed;
				default: ; // unknown code
			endcase
		end
	end

	assign d_right = btn_right | joystick_0[0] | joystick_1[0];
	assign d_left  = btn_left  | joystick_0[1] | joystick_1[1];
	assign d_down  = btn_down  | joystick_0[2] | joystick_1[2];
	assign d_up    = btn_up    | joystick_0[3] | joystick_1[3];
	assign m_fire1 = btn_fire1 | joystick_0[4] | joystick_1[4];
	assign m_fire2 = btn_fire2 | joystick_0[5] | joystick_1[5];

	// rotated cabinet, screen turned a quarter
	assign m_up    = rotate ? d_left  : d_up;
	assign m_down  = rotate ? d_right : d_down;
	assign m_left  = rotate ? d_down  : d_left;
	assign m_right = rotate ? d_up    : d_right;

	assign inp0 = {m_fire2, m_fire1, m_left, m_down, m_right, m_up};
	assign inp1 = inp0; // both players share the controls
	assign inp2 = {btn_coin, btn_start2, btn_start1};

endmodule

`default_nettype wire

// File: src/ioctl_if.sv
`timescale 1ns/1ps
`default_nettype none

// byte-wide rom download stream
interface ioctl_if;
	logic        download; // high for the whole transfer
	logic [7:0]  index;    // 0 is the game rom
	logic        wr;
	logic [24:0] addr;     // byte address
	logic [7:0]  dout;

	modport source (output download, index, wr, addr, dout);
	modport sink (input download, index, wr, addr, dout);
endinterface

`default_nettype wire

// File: src/option_regs.sv
`timescale 1ns/1ps
`default_nettype none

module option_regs (
	input  wire        clock_48,
	input  wire        arst_n,
	input  wire        cfg_wr,
	input  wire [1:0]  cfg_addr,
	input  wire [7:0]  cfg_wdata,
	output logic [7:0] cfg_rdata,
	input  wire        download,
	input  wire        rom_loaded,
	input  wire        button_reset,
	output logic       rotate,
	output logic [1:0] scanlines,
	output logic       core_reset
);
	import arcade_pkg::*;

	logic soft_reset;

	always_ff @(posedge clock_48 or negedge arst_n) begin
		if (!arst_n) begin
			soft_reset <= 1'b0;
			rotate     <= 1'b0;
			scanlines  <= 2'd0;
		end else if (cfg_wr) begin
			case (cfg_addr)
				reg_ctrl: begin
					soft_reset <= cfg_wdata[0];
					rotate     <= cfg_wdata[1];
				end
				reg_video: scanlines <= cfg_wdata[1:0];
				default: ; // status is read only
			endcase
		end
	end

	// core held in reset until a complete rom is in place
	always_ff @(posedge clock_48 or negedge arst_n) begin
		if (!arst_n)
			core_reset <= 1'b1;
		else
			core_reset <= soft_reset | button_reset | download | ~rom_loaded;
	end

	always_comb begin
		case (cfg_addr)
			reg_ctrl:   cfg_rdata = {6'd0, rotate, soft_reset};
			reg_video:  cfg_rdata = {6'd0, scanlines};
			reg_status: cfg_rdata = {6'd0, core_reset, rom_loaded};
			default:    cfg_rdata = 8'h00;
		endcase
	end

endmodule

`default_nettype wire

// File: src/rom_banks.sv
`timescale 1ns/1ps
`default_nettype none

module rom_banks #(
	parameter int CPU_AW = arcade_pkg::cpu_rom_aw,
	parameter int SND_AW = arcade_pkg::snd_rom_aw
) (
	input  wire              clock_48,
	rom_wr_if.banks          wr_port,
	input  wire              download,
	input  wire [CPU_AW-1:0] cpu_addr, // byte address
	input  wire [SND_AW-1:0] snd_addr, // byte address
	output logic [7:0]       cpu_data,
	output logic [7:0]       snd_data
);
	import arcade_pkg::*;

	logic [15:0] cpu_mem [2**(CPU_AW-1)];
	logic [15:0] snd_mem [2**(SND_AW-1)];

	logic [15:0] cpu_word;
	logic [15:0] snd_word;
	logic        cpu_odd;
	logic        snd_odd;

	// byte-enable writes from the loader
	always_ff @(posedge clock_48) begin
		if (wr_port.we && wr_port.bank == region_cpu) begin
			if (wr_port.ds[0])
				cpu_mem[wr_port.word_addr[CPU_AW-2:0]][7:0] <= wr_port.data[7:0];
			if (wr_port.ds[1])
				cpu_mem[wr_port.word_addr[CPU_AW-2:0]][15:8] <= wr_port.data[15:8];
		end
		if (wr_port.we && wr_port.bank == region_snd) begin
			if (wr_port.ds[0])
				snd_mem[wr_port.word_addr[SND_AW-2:0]][7:0] <= wr_port.data[7:0];
			if (wr_port.ds[1])
				snd_mem[wr_port.word_addr[SND_AW-2:0]][15:8] <= wr_port.data[15:8];
		end
	end

	// registered word reads, byte picked after the register
	always_ff @(posedge clock_48) begin
		cpu_word <= cpu_mem[cpu_addr[CPU_AW-1:1]];
		cpu_odd  <= cpu_addr[0];
		snd_word <= snd_mem[snd_addr[SND_AW-1:1]];
		snd_odd  <= snd_addr[0];
	end

	// core sees 0 while the rom is being loaded
	assign cpu_data = download ? 8'h00 : (cpu_odd ? cpu_word[15:8] : cpu_word[7:0]);
	assign snd_data = download ? 8'h00 : (snd_odd ? snd_word[15:8] : snd_word[7:0]);

endmodule

`default_nettype wire

// File: src/rom_loader.sv
`timescale 1ns/1ps
`default_nettype none

module rom_loader (
	input  wire       clock_48,
	input  wire       arst_n,
	ioctl_if.sink     ioctl,
	rom_wr_if.loader  wr_port,
	output logic      rom_loaded
);
	import arcade_pkg::*;

	localparam logic [24:0] cpu_top = 25'd1 << cpu_rom_aw;
	localparam logic [24:0] snd_top = snd_base + (25'd1 << snd_rom_aw);

	logic        wr_q;
	logic        download_q;
	logic        rom_index;
	logic        wr_rise;
	logic        accept;
	rom_region_t region;
	logic [24:0] rel_addr;

	assign rom_index = (ioctl.index == 8'd0); // other indices are not rom data
	assign wr_rise   = ioctl.download & ioctl.wr & ~wr_q & rom_index;
	assign accept    = wr_rise && (region != region_none);

	// address decode into region and offset
	always_comb begin
		region   = region_none;
		rel_addr = ioctl.addr;
		if (ioctl.addr < cpu_top) begin
			region = region_cpu;
		end else if (ioctl.addr >= snd_base && ioctl.addr < snd_top) begin
			region   = region_snd;
			rel_addr = ioctl.addr - snd_base;
		end
	end

	always_ff @(posedge clock_48 or negedge arst_n) begin
		if (!arst_n) begin
			wr_q       <= 1'b0;
			download_q <= 1'b0;
			wr_port.we <= 1'b0;
			rom_loaded <= 1'b0;
		end else begin
			wr_q       <= ioctl.wr;
			download_q <= ioctl.download;
			wr_port.we <= accept;
			if (download_q && !ioctl.download)
				rom_loaded <= 1'b1; // sticky until arst_n
		end
	end

	// write payload, held until the next accepted byte
	always_ff @(posedge clock_48) begin
		if (accept) begin
			wr_port.bank      <= region;
			wr_port.word_addr <= rel_addr[15:1];
			wr_port.ds        <= {ioctl.addr[0], ~ioctl.addr[0]}; // odd -> upper byte
			wr_port.data      <= {ioctl.dout, ioctl.dout};
		end
	end

endmodule

`default_nettype wire

// File: src/rom_wr_if.sv
`timescale 1ns/1ps
`default_nettype none

// word writes from the loader into the rom banks
interface rom_wr_if;
	import arcade_pkg::*;

	logic        we; // one cycle pulse
	rom_region_t bank;
	logic [14:0] word_addr; // relative to the region base
	logic [1:0]  ds;        // byte enables, bit 1 is the upper byte
	logic [15:0] data;

	modport loader (output we, bank, word_addr, ds, data);
	modport banks (input we, bank, word_addr, ds, data);
endinterface

`default_nettype wire

// File: src/video_out.sv
`timescale 1ns/1ps
`default_nettype none

module video_out (
	input  wire        clock_48,
	input  wire        arst_n,
	input  wire [2:0]  r,
	input  wire [2:0]  g,
	input  wire [1:0]  b,
	input  wire        hblank,
	input  wire        vblank,
	input  wire        hsync,
	input  wire        vsync,
	input  wire        vpos_odd,
	input  wire [1:0]  scanlines,
	output logic [5:0] vga_r,
	output logic [5:0] vga_g,
	output logic [5:0] vga_b,
	output logic       vga_hs,
	output logic       vga_vs
);

	logic       blank;
	logic [1:0] level;
	logic [5:0] r6;
	logic [5:0] g6;
	logic [5:0] b6;

	// v - v*s/4, s = 0..3
	function automatic logic [5:0] dim(input logic [5:0] v, input logic [1:0] s);
		logic [7:0] prod;
		prod = {2'b00, v} * {6'd0, s};
		return v - prod[7:2];
	endfunction

	assign blank = hblank | vblank;
	assign level = vpos_odd ? scanlines : 2'd0; // even lines stay bright

	// bit replication to 6 bits
	assign r6 = blank ? 6'd0 : {r, r};
	assign g6 = blank ? 6'd0 : {g, g};
	assign b6 = blank ? 6'd0 : {b, b, b};

	always_ff @(posedge clock_48 or negedge arst_n) begin
		if (!arst_n) begin
			vga_r  <= 6'd0;
			vga_g  <= 6'd0;
			vga_b  <= 6'd0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
		end else begin
			vga_r  <= dim(r6, level);
			vga_g  <= dim(g6, level);
			vga_b  <= dim(b6, level);
			vga_hs <= hsync; // keep sync aligned with colour
			vga_vs <= vsync;
		end
	end

endmodule

`default_nettype wire
